/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // data word, also used for byte addresses and the PC
    typedef logic [31:0] wordT;
    // cache word address, byte offset dropped
    typedef logic [29:0] wordAddrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [15:0] immT;

    typedef enum logic [5:0] {
        opR    = 6'h00,
        opBeq  = 6'h04,
        opAddi = 6'h08,
        opLw   = 6'h23,
        opSw   = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluCtrlT;

    // operand source in execute
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelT;

    localparam wordT RESET_PC = 32'h0000_0000;
    localparam int   NUM_REGS = 32;

endpackage

`default_nettype wire

/* design/pipeIf.sv */
`timescale 1ns/1ps
`default_nettype none

// ID/EX pipeline register contents
interface decodeExecuteIf;
    import mipsPkg::*;

    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    branch;
    logic    aluSrcImm;
    aluCtrlT aluCtrl;
    wordT    rsVal;
    wordT    rtVal;
    // already sign extended
    wordT    imm;
    regIdxT  rs;
    regIdxT  rt;
    regIdxT  wsel;
    wordT    branchTarget;

    modport drive (
        output regWrite, memRead, memWrite, branch, aluSrcImm, aluCtrl,
        output rsVal, rtVal, imm, rs, rt, wsel, branchTarget
    );

    modport receive (
        input regWrite, memRead, memWrite, branch, aluSrcImm, aluCtrl,
        input rsVal, rtVal, imm, rs, rt, wsel, branchTarget
    );
endinterface

// EX/MEM pipeline register contents
interface executeMemoryIf;
    import mipsPkg::*;

    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    wordT   aluOut;
    wordT   storeData;
    regIdxT wsel;
    logic   branchTaken;
    wordT   branchTarget;

    modport drive (
        output regWrite, memRead, memWrite, aluOut, storeData, wsel,
        output branchTaken, branchTarget
    );

    modport receive (
        input regWrite, memRead, memWrite, aluOut, storeData, wsel,
        input branchTaken, branchTarget
    );
endinterface

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 pipeStall,
    input  wire                 loadStall,
    executeMemoryIf.receive     exMem,
    input  wire mipsPkg::wordT  icacheRdata,
    output mipsPkg::wordAddrT   icacheAddr,
    output mipsPkg::wordT       instr,
    output mipsPkg::wordT       pcPlus4
);
    import mipsPkg::*;

    wordT pc;
    wordT seqPc;
    wordT nextPc;
    logic advance;

    assign seqPc  = pc + 32'd4;
    assign nextPc = exMem.branchTaken ? exMem.branchTarget : seqPc;

    // a taken branch wins over the load-use hold, the held instruction is wrong path
    assign advance = !pipeStall && (exMem.branchTaken || !loadStall);

    assign icacheAddr = pc[31:2];

    //////////////////////////////////////////////////
    // PC and IF/ID

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            instr <= '0;
        end else if (advance) begin
            pc <= nextPc;
            // all-zero word decodes as nop
            instr <= exMem.branchTaken ? '0 : icacheRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pcPlus4 <= seqPc;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire mipsPkg::regIdxT  rs,
    input  wire mipsPkg::regIdxT  rt,
    output mipsPkg::wordT         rsVal,
    output mipsPkg::wordT         rtVal,
    input  wire                   wbWrite,
    input  wire mipsPkg::regIdxT  wbSel,
    input  wire mipsPkg::wordT    wbData
);
    import mipsPkg::*;

    wordT regs [NUM_REGS];

    // register zero is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite && wbSel != '0) begin
            regs[wbSel] <= wbData;
        end
    end

    // write-first bypass
    always_comb begin
        if (rs == '0) begin
            rsVal = '0;
        end else if (wbWrite && wbSel == rs) begin
            rsVal = wbData;
        end else begin
            rsVal = regs[rs];
        end
    end

    always_comb begin
        if (rt == '0) begin
            rtVal = '0;
        end else if (wbWrite && wbSel == rt) begin
            rtVal = wbData;
        end else begin
            rtVal = regs[rt];
        end
    end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   pipeStall,
    input  wire                   branchTaken,
    input  wire mipsPkg::wordT    instr,
    input  wire mipsPkg::wordT    pcPlus4,
    input  wire                   wbWrite,
    input  wire mipsPkg::regIdxT  wbSel,
    input  wire mipsPkg::wordT    wbData,
    output logic                  loadStall,
    decodeExecuteIf.drive         idEx
);
    import mipsPkg::*;

    opcodeT  opcode;
    functT   funct;
    regIdxT  rs;
    regIdxT  rt;
    regIdxT  rd;
    regIdxT  wsel;
    immT     immField;
    wordT    immExt;
    wordT    rsVal;
    wordT    rtVal;
    wordT    branchTarget;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    branch;
    logic    aluSrcImm;
    logic    useRd;
    aluCtrlT aluCtrl;

    assign opcode   = opcodeT'(instr[31:26]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign immField = instr[15:0];
    assign funct    = functT'(instr[5:0]);

    regFile regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .rsVal   (rsVal),
        .rtVal   (rtVal),
        .wbWrite (wbWrite),
        .wbSel   (wbSel),
        .wbData  (wbData)
    );

    //////////////////////////////////////////////////
    // main decoder

    always_comb begin
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        aluSrcImm = 1'b0;
        useRd     = 1'b0;
        aluCtrl   = aluAdd;
        case (opcode)
            opR: begin
                useRd    = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    fnAdd:   aluCtrl = aluAdd;
                    fnSub:   aluCtrl = aluSub;
                    fnAnd:   aluCtrl = aluAnd;
                    fnOr:    aluCtrl = aluOr;
                    fnSlt:   aluCtrl = aluSlt;
                    // unsupported funct, including the nop word
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opLw: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                aluSrcImm = 1'b1;
            end
            opSw: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opBeq: begin
                branch  = 1'b1;
                aluCtrl = aluSub;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

    assign wsel         = useRd ? rd : rt;
    assign immExt       = {{16{immField[15]}}, immField};
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};

    // load in EX whose result is needed by the instruction in ID
    assign loadStall = idEx.memRead && idEx.wsel != '0 &&
                       (idEx.wsel == rs || idEx.wsel == rt);

    //////////////////////////////////////////////////
    // ID/EX register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.branch   <= 1'b0;
        end else if (!pipeStall) begin
            // bubble on load-use and on a taken branch
            idEx.regWrite <= regWrite && !loadStall && !branchTaken;
            idEx.memRead  <= memRead && !loadStall && !branchTaken;
            idEx.memWrite <= memWrite && !loadStall && !branchTaken;
            idEx.branch   <= branch && !loadStall && !branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipeStall) begin
            idEx.aluSrcImm    <= aluSrcImm;
            idEx.aluCtrl      <= aluCtrl;
            idEx.rsVal        <= rsVal;
            idEx.rtVal        <= rtVal;
            idEx.imm          <= immExt;
            idEx.rs           <= rs;
            idEx.rt           <= rt;
            idEx.wsel         <= wsel;
            idEx.branchTarget <= branchTarget;
        end
    end

    bubbleNoWrite: assert property (@(posedge clk) disable iff (!rst_n)
        (!pipeStall && (loadStall || branchTaken)) |=> !idEx.regWrite);

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   pipeStall,
    decodeExecuteIf.receive       idEx,
    input  wire                   wbWrite,
    input  wire mipsPkg::regIdxT  wbSel,
    input  wire mipsPkg::wordT    wbData,
    executeMemoryIf.drive         exMem
);
    import mipsPkg::*;

    fwdSelT fwdA;
    fwdSelT fwdB;
    wordT   opA;
    wordT   rtFwd;
    wordT   opB;
    wordT   aluOut;
    logic   branchTaken;

    // EX/MEM has priority over writeback, register zero is never forwarded
    function automatic fwdSelT fwdFor(input regIdxT src, input logic memWr,
                                      input regIdxT memSel, input logic wbWr,
                                      input regIdxT wbDst);
        fwdSelT sel;
        sel = fwdNone;
        if (memWr && memSel != '0 && memSel == src) begin
            sel = fwdMem;
        end else if (wbWr && wbDst != '0 && wbDst == src) begin
            sel = fwdWb;
        end
        return sel;
    endfunction

    function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal,
                                    input wordT memVal, input wordT wbVal);
        wordT val;
        case (sel)
            fwdMem:  val = memVal;
            fwdWb:   val = wbVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

    assign fwdA  = fwdFor(idEx.rs, exMem.regWrite, exMem.wsel, wbWrite, wbSel);
    assign fwdB  = fwdFor(idEx.rt, exMem.regWrite, exMem.wsel, wbWrite, wbSel);
    assign opA   = fwdMux(fwdA, idEx.rsVal, exMem.aluOut, wbData);
    assign rtFwd = fwdMux(fwdB, idEx.rtVal, exMem.aluOut, wbData);
    assign opB   = idEx.aluSrcImm ? idEx.imm : rtFwd;

    //////////////////////////////////////////////////
    // ALU and branch compare

    always_comb begin
        case (idEx.aluCtrl)
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluSlt:  aluOut = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
            default: aluOut = opA + opB;
        endcase
    end

    assign branchTaken = idEx.branch && (opA == rtFwd);

    //////////////////////////////////////////////////
    // EX/MEM register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem.regWrite    <= 1'b0;
            exMem.memRead     <= 1'b0;
            exMem.memWrite    <= 1'b0;
            exMem.branchTaken <= 1'b0;
        end else if (!pipeStall) begin
            // wrong-path instruction is squashed while the branch sits in MEM
            exMem.regWrite    <= idEx.regWrite && !exMem.branchTaken;
            exMem.memRead     <= idEx.memRead && !exMem.branchTaken;
            exMem.memWrite    <= idEx.memWrite && !exMem.branchTaken;
            exMem.branchTaken <= branchTaken && !exMem.branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipeStall) begin
            exMem.aluOut       <= aluOut;
            exMem.storeData    <= rtFwd;
            exMem.wsel         <= idEx.wsel;
            exMem.branchTarget <= idEx.branchTarget;
        end
    end

    takenOnePulse: assert property (@(posedge clk) disable iff (!rst_n)
        (exMem.branchTaken && !pipeStall) |=> !exMem.branchTaken);

endmodule

`default_nettype wire

/* design/memWbStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  pipeStall,
    executeMemoryIf.receive      exMem,
    input  wire mipsPkg::wordT   dcacheRdata,
    output logic                 dcacheRead,
    output logic                 dcacheWrite,
    output mipsPkg::wordAddrT    dcacheAddr,
    output mipsPkg::wordT        dcacheWdata,
    output logic                 wbWrite,
    output mipsPkg::regIdxT      wbSel,
    output mipsPkg::wordT        wbData
);
    import mipsPkg::*;

    logic memToReg;
    wordT loadData;
    wordT aluOutWb;

    // data request straight from EX/MEM
    assign dcacheRead  = exMem.memRead;
    assign dcacheWrite = exMem.memWrite;
    assign dcacheAddr  = exMem.aluOut[31:2];
    assign dcacheWdata = exMem.storeData;

    //////////////////////////////////////////////////
    // MEM/WB register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbWrite  <= 1'b0;
            memToReg <= 1'b0;
        end else if (!pipeStall) begin
            wbWrite  <= exMem.regWrite;
            memToReg <= exMem.memRead;
        end
    end

    // rdata is valid once the stall has dropped
    always_ff @(posedge clk) begin
        if (!pipeStall) begin
            loadData <= dcacheRdata;
            aluOutWb <= exMem.aluOut;
            wbSel    <= exMem.wsel;
        end
    end

    assign wbData = memToReg ? loadData : aluOutWb;

    oneRequest: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRead && dcacheWrite));

endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  icacheStall,
    input  wire mipsPkg::wordT   icacheRdata,
    output mipsPkg::wordAddrT    icacheAddr,
    input  wire                  dcacheStall,
    input  wire mipsPkg::wordT   dcacheRdata,
    output logic                 dcacheRead,
    output logic                 dcacheWrite,
    output mipsPkg::wordAddrT    dcacheAddr,
    output mipsPkg::wordT        dcacheWdata
);
    import mipsPkg::*;

    logic   pipeStall;
    logic   loadStall;
    wordT   instr;
    wordT   pcPlus4;
    logic   wbWrite;
    regIdxT wbSel;
    wordT   wbData;

    decodeExecuteIf idEx ();
    executeMemoryIf exMem ();

    // either cache busy freezes the whole pipeline
    assign pipeStall = icacheStall | dcacheStall;

    fetchStage fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .pipeStall   (pipeStall),
        .loadStall   (loadStall),
        .exMem       (exMem.receive),
        .icacheRdata (icacheRdata),
        .icacheAddr  (icacheAddr),
        .instr       (instr),
        .pcPlus4     (pcPlus4)
    );

    decodeStage decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .pipeStall   (pipeStall),
        .branchTaken (exMem.branchTaken),
        .instr       (instr),
        .pcPlus4     (pcPlus4),
        .wbWrite     (wbWrite),
        .wbSel       (wbSel),
        .wbData      (wbData),
        .loadStall   (loadStall),
        .idEx        (idEx.drive)
    );

    executeStage execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .pipeStall (pipeStall),
        .idEx      (idEx.receive),
        .wbWrite   (wbWrite),
        .wbSel     (wbSel),
        .wbData    (wbData),
        .exMem     (exMem.drive)
    );

    memWbStage memWb (
        .clk         (clk),
        .rst_n       (rst_n),
        .pipeStall   (pipeStall),
        .exMem       (exMem.receive),
        .dcacheRdata (dcacheRdata),
        .dcacheRead  (dcacheRead),
        .dcacheWrite (dcacheWrite),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata),
        .wbWrite     (wbWrite),
        .wbSel       (wbSel),
        .wbData      (wbData)
    );

endmodule

`default_nettype wire

/* dv/tbMemModel.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMemModel (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         stallEn,
    input  wire [29:0]  icacheAddr,
    output logic [31:0] icacheRdata,
    output logic        icacheStall,
    input  wire         dcacheRead,
    input  wire         dcacheWrite,
    input  wire [29:0]  dcacheAddr,
    input  wire [31:0]  dcacheWdata,
    output logic [31:0] dcacheRdata,
    output logic        dcacheStall
);
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] rngState = 32'd67;
    logic [1:0]  iCount = 2'd0;
    logic [1:0]  dCount = 2'd0;
    logic        iStall = 1'b0;
    logic        dStall = 1'b0;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // both memories wrap at 256 words
    // inverted words stand in for data that is not valid yet
    assign icacheRdata = iStall ? ~imem[icacheAddr[7:0]] : imem[icacheAddr[7:0]];
    assign dcacheRdata = (dcacheRead && !dStall) ? dmem[dcacheAddr[7:0]] :
                                                   ~dmem[dcacheAddr[7:0]];
    assign icacheStall = iStall;
    assign dcacheStall = dStall;

    //////////////////////////////////////////////////
    // stall injection of 0 to 3 cycles per burst

    always @(negedge clk) begin
        if (!rst_n || !stallEn) begin
            iCount = 2'd0;
            dCount = 2'd0;
            iStall <= 1'b0;
            dStall <= 1'b0;
        end else begin
            rngState = xorshift32(rngState);
            if (iCount != 2'd0) begin
                iStall <= 1'b1;
                iCount = iCount - 2'd1;
            end else begin
                iStall <= 1'b0;
                iCount = rngState[1:0];
            end
            // data stalls only while a data request is up
            if (dCount != 2'd0 && (dcacheRead || dcacheWrite)) begin
                dStall <= 1'b1;
                dCount = dCount - 2'd1;
            end else begin
                dStall <= 1'b0;
                if (dCount == 2'd0) begin
                    dCount = rngState[9:8];
                end
            end
        end
    end

    // data fill pattern depends on every address bit
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= {~8'(i), 8'(i), 8'(i) ^ 8'h5a, 8'hc3};
            end
        end else if (dcacheWrite && !dcacheStall && !icacheStall) begin
            dmem[dcacheAddr[7:0]] <= dcacheWdata;
        end
    end

endmodule

`default_nettype wire

/* dv/tbMipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore;
    import mipsPkg::*;

    localparam int BODY_LEN = 48;
    localparam int MAX_WAIT = 20000;

    logic        clk;
    logic        rst_n;
    logic        stallEn;
    logic        icacheStall;
    logic        dcacheStall;
    logic [31:0] icacheRdata;
    logic [31:0] dcacheRdata;
    logic [29:0] icacheAddr;
    logic [29:0] dcacheAddr;
    logic [31:0] dcacheWdata;
    logic        dcacheRead;
    logic        dcacheWrite;

    logic [31:0] rngState = 32'd67;
    logic [31:0] prog [256];
    logic [29:0] expAddr [$];
    logic [31:0] expData [$];
    int          obsCount = 0;
    int          monErrors = 0;
    int          otherErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    mipsCore UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheStall (icacheStall),
        .icacheRdata (icacheRdata),
        .icacheAddr  (icacheAddr),
        .dcacheStall (dcacheStall),
        .dcacheRdata (dcacheRdata),
        .dcacheRead  (dcacheRead),
        .dcacheWrite (dcacheWrite),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata)
    );

    tbMemModel mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .stallEn     (stallEn),
        .icacheAddr  (icacheAddr),
        .icacheRdata (icacheRdata),
        .icacheStall (icacheStall),
        .dcacheRead  (dcacheRead),
        .dcacheWrite (dcacheWrite),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata),
        .dcacheRdata (dcacheRdata),
        .dcacheStall (dcacheStall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // small register range so that dependencies are frequent
    function automatic regIdxT pickReg();
        logic [31:0] r;
        r = nextRand();
        return regIdxT'(r % 8);
    endfunction

    function automatic logic [31:0] rType(input regIdxT rs, input regIdxT rt,
                                          input regIdxT rd, input logic [2:0] sel);
        functT fn;
        case (sel)
            3'd0:    fn = fnAdd;
            3'd1:    fn = fnSub;
            3'd2:    fn = fnAnd;
            3'd3:    fn = fnOr;
            default: fn = fnSlt;
        endcase
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] iType(input opcodeT op, input regIdxT rs,
                                          input regIdxT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    //////////////////////////////////////////////////
    // program generator

    task automatic genProgram(input bit useLoads, input bit useBranches);
        int          i;
        int          off;
        logic [31:0] r;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      lastDst;
        i = 0;
        lastDst = 5'd1;
        for (int k = 0; k < 256; k++) begin
            prog[k] = 32'h0;
        end
        while (i < BODY_LEN) begin
            r  = nextRand();
            rs = r[4] ? lastDst : pickReg();
            rt = pickReg();
            if (useLoads && r[2:0] == 3'd0 && i + 1 < BODY_LEN) begin
                // load followed at once by a use
                prog[i] = iType(opLw, rs, rt, r[31:16]);
                lastDst = pickReg();
                prog[i + 1] = rType(rt, pickReg(), lastDst, r[7:5]);
                i = i + 2;
            end else if (useLoads && r[2:0] == 3'd1) begin
                prog[i] = iType(opSw, pickReg(), rs, r[31:16]);
                i = i + 1;
            end else if (useBranches && r[2:0] == 3'd2) begin
                off = 1 + int'(r[17:16]) % 3;
                if (i + 1 + off > BODY_LEN) begin
                    off = BODY_LEN - i - 1;
                end
                prog[i] = iType(opBeq, rs, r[18] ? rs : rt, 16'(off));
                i = i + 1;
            end else if (r[2:0] == 3'd3) begin
                lastDst = pickReg();
                prog[i] = iType(opAddi, rs, lastDst, r[31:16]);
                i = i + 1;
            end else begin
                lastDst = pickReg();
                prog[i] = rType(rs, rt, lastDst, r[7:5]);
                i = i + 1;
            end
        end
        // dump all registers and spin
        for (int k = 1; k < 32; k++) begin
            prog[BODY_LEN + k - 1] = iType(opSw, 5'd0, regIdxT'(k), 16'(32'h400 + 4 * k));
        end
        prog[BODY_LEN + 31] = iType(opBeq, 5'd0, 5'd0, 16'hffff);
    endtask

    //////////////////////////////////////////////////
    // sequential reference model

    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] dm [256];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [5:0]  op;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        int          pc;
        int          steps;
        expAddr.delete();
        expData.delete();
        for (int k = 0; k < 32; k++) begin
            regs[k] = 32'h0;
        end
        for (int k = 0; k < 256; k++) begin
            dm[k] = mem.dmem[k];
        end
        pc = 0;
        steps = 0;
        while (steps < 2000) begin
            w    = prog[pc];
            op   = w[31:26];
            rs   = w[25:21];
            rt   = w[20:16];
            rd   = w[15:11];
            sext = {{16{w[15]}}, w[15:0]};
            a    = regs[rs];
            b    = regs[rt];
            addr = a + sext;
            steps++;
            if (op == 6'h04 && rs == 5'd0 && rt == 5'd0 && w[15:0] == 16'hffff) begin
                break;
            end
            pc++;
            case (op)
                6'h00: begin
                    if (rd != 5'd0) begin
                        case (w[5:0])
                            6'h20: regs[rd] = a + b;
                            6'h22: regs[rd] = a - b;
                            6'h24: regs[rd] = a & b;
                            6'h25: regs[rd] = a | b;
                            6'h2a: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            default: ;
                        endcase
                    end
                end
                6'h08: if (rt != 5'd0) regs[rt] = addr;
                6'h23: if (rt != 5'd0) regs[rt] = dm[addr[9:2]];
                6'h2b: begin
                    expAddr.push_back(addr[31:2]);
                    expData.push_back(b);
                    dm[addr[9:2]] = b;
                end
                6'h04: if (a == b) pc = pc + int'($signed(sext));
                default: ;
            endcase
        end
        if (steps >= 2000) begin
            $display("reference model did not reach the end of the program");
            otherErrors++;
        end
    endtask

    // store monitor against the predicted sequence
    always @(posedge clk) begin
        if (!rst_n) begin
            obsCount <= 0;
        end else if (dcacheWrite && !dcacheStall && !icacheStall) begin
            if (obsCount >= expAddr.size()) begin
                $display("time %0t: store of %h to %h beyond the predicted sequence",
                         $time, dcacheWdata, dcacheAddr);
                monErrors <= monErrors + 1;
            end else if (dcacheAddr != expAddr[obsCount] ||
                         dcacheWdata != expData[obsCount]) begin
                $display("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, obsCount, dcacheWdata, dcacheAddr,
                         expData[obsCount], expAddr[obsCount]);
                monErrors <= monErrors + 1;
            end
            obsCount <= obsCount + 1;
        end
    end

    task automatic runTest(input string name, input bit useLoads, input bit useBranches,
                           input bit withStalls, input bit newProgram);
        int cycles;
        int errorsBefore;
        int testErrors;
        if (newProgram) begin
            genProgram(useLoads, useBranches);
        end
        rst_n = 1'b0;
        stallEn = withStalls;
        repeat (10) @(negedge clk);
        for (int k = 0; k < 256; k++) begin
            mem.imem[k] = prog[k];
        end
        errorsBefore = monErrors + otherErrors;
        runModel();
        rst_n = 1'b1;
        cycles = 0;
        while (obsCount < expAddr.size() && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (obsCount < expAddr.size()) begin
            $display("test %s timed out with %0d of %0d stores seen",
                     name, obsCount, expAddr.size());
            otherErrors++;
        end else begin
            // catch any extra store after the last one
            repeat (40) @(negedge clk);
        end
        testErrors = monErrors + otherErrors - errorsBefore;
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("test %s: %0d stores, %0d errors", name, expAddr.size(), testErrors);
    endtask

    initial begin
        int errorsBefore;
        rst_n = 1'b0;
        stallEn = 1'b0;
        for (int k = 0; k < 256; k++) begin
            mem.imem[k] = 32'h0;
        end
        mem.imem[0] = {6'h04, 5'd0, 5'd0, 16'hffff};

        // reset values seen right after release
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        errorsBefore = otherErrors;
        if (icacheAddr != 30'd0 || dcacheRead || dcacheWrite) begin
            $display("Mismatch at %0t: after reset icacheAddr %h read %b write %b",
                     $time, icacheAddr, dcacheRead, dcacheWrite);
            otherErrors++;
        end
        testsRun++;
        if (otherErrors != errorsBefore) begin
            testsFailed++;
        end
        $display("test reset: %0d errors", otherErrors - errorsBefore);

        runTest("alu chains", 1'b0, 1'b0, 1'b0, 1'b1);
        runTest("load use", 1'b1, 1'b0, 1'b0, 1'b1);
        runTest("branches", 1'b1, 1'b1, 1'b0, 1'b1);
        runTest("mixed without stalls", 1'b1, 1'b1, 1'b0, 1'b1);
        runTest("mixed with cache stalls", 1'b1, 1'b1, 1'b1, 1'b0);

        $display("%0d tests run, %0d failed, %0d errors",
                 testsRun, testsFailed, monErrors + otherErrors);
        if (testsFailed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/mipsPkg.sv
design/pipeIf.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/mipsCore.sv
dv/tbMemModel.sv
dv/tbMipsCore.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tbMipsCore -o simMipsCore

./obj_dir/simMipsCore | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
